// ==== Makefile ====
SIM  = obj_dir/Vtb_crop_top
SRCS = list.f crop_defines.svh crop_pkg.sv raster_tracker.sv window_gate.sv \
       crop_ctrl.sv crop_stream_out.sv crop_top.sv tb_crop_top.sv

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_crop_top -f list.f

# Pass or fail comes from the log, not from the exit code
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== crop_ctrl.sv ====
`timescale 1ns/1ps
`include "crop_defines.svh"

module crop_ctrl (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    fsync,
	input  logic                    cfg_wr,
	input  logic                    cfg_sel,
	input  crop_pkg::cfg_word_u     cfg_word,
	input  logic                    beat_valid,
	output crop_pkg::win_cfg_t      win,
	output logic [31:0]             frame_count,
	output logic [`CROP_PCNT_W-1:0] last_frame_pixels
);

	import crop_pkg::*;

	win_pos_t  pend_pos;
	win_size_t pend_size;

	logic [`CROP_PCNT_W-1:0] pix_cnt;

	////////////////////
	// Host write port
	////////////////////

	// Same word read as origin or as size
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pend_pos  <= '0;
			pend_size <= '0;
		end else if (cfg_wr) begin
			if (cfg_sel)
				pend_size <= cfg_word.size;
			else
				pend_pos <= cfg_word.pos;
		end
	end

	////////////////////
	// Window activation
	////////////////////

	// A write in the fsync cycle lands in the next frame
	always_ff @(posedge clk) begin
		if (!resetn)
			win <= '0;
		else if (fsync) begin
			win.pos  <= pend_pos;
			win.size <= pend_size;
		end
	end

	////////////////////
	// Frame statistics
	////////////////////

	always_ff @(posedge clk) begin
		if (!resetn)
			frame_count <= '0;
		else if (fsync)
			frame_count <= frame_count + 1'b1;
	end

	// Beat in the fsync cycle still belongs to the old frame
	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_cnt           <= '0;
			last_frame_pixels <= '0;
		end else if (fsync) begin
			last_frame_pixels <= pix_cnt + beat_valid;
			pix_cnt           <= '0;
		end else if (beat_valid) begin
			pix_cnt <= pix_cnt + 1'b1;
		end
	end

endmodule

// ==== crop_defines.svh ====
`ifndef CROP_DEFINES_SVH
`define CROP_DEFINES_SVH

////////////////////
// Stream widths
////////////////////

// Bits per pixel sample
`define CROP_PIX_W 8

// Column index, enough for 4096 pixels per line
`define CROP_COL_W 12

// Row index, enough for 4096 lines per frame
`define CROP_ROW_W 12

////////////////////
// Derived widths
////////////////////

// Pixels per frame counter
`define CROP_PCNT_W (`CROP_COL_W + `CROP_ROW_W)

`endif

// ==== crop_pkg.sv ====
`include "crop_defines.svh"

package crop_pkg;

	////////////////////
	// Window description
	////////////////////

	// Window origin, first column and first row
	typedef struct packed {
		logic [`CROP_COL_W-1:0] left;
		logic [`CROP_ROW_W-1:0] top;
	} win_pos_t;

	// Window extent in pixels and lines
	typedef struct packed {
		logic [`CROP_COL_W-1:0] width;
		logic [`CROP_ROW_W-1:0] height;
	} win_size_t;

	// Host data word, origin or size by cfg_sel
	typedef union packed {
		win_pos_t  pos;
		win_size_t size;
	} cfg_word_u;

	// Active window used by the gate
	typedef struct packed {
		win_pos_t  pos;
		win_size_t size;
	} win_cfg_t;

	////////////////////
	// Stream records
	////////////////////

	// Position of the pixel now leaving the tracker
	typedef struct packed {
		logic [`CROP_COL_W-1:0] col_idx;
		logic [`CROP_COL_W-1:0] col_idx_next;
		logic                   col_update;
		logic [`CROP_ROW_W-1:0] row_idx;
		logic                   row_update;
	} raster_pos_t;

	// One output beat
	typedef struct packed {
		logic                   valid;
		logic                   sof;
		logic                   eol;
		logic [`CROP_PIX_W-1:0] data;
	} crop_pix_t;

endpackage

// ==== crop_stream_out.sv ====
`timescale 1ns/1ps
`include "crop_defines.svh"

module crop_stream_out (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [`CROP_PIX_W-1:0] pix_dly,
	input  logic                   need,
	input  logic                   sof,
	input  logic                   eol,
	output crop_pkg::crop_pix_t    out
);

	// Pixel held while the gate computes its flags
	logic [`CROP_PIX_W-1:0] pix_q;

	////////////////////
	// Data alignment
	////////////////////

	always_ff @(posedge clk) begin
		pix_q <= pix_dly;
	end

	////////////////////
	// Output beat
	////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out.valid <= 1'b0;
			out.sof   <= 1'b0;
			out.eol   <= 1'b0;
		end else begin
			out.valid <= need;
			// Markers only on beats that pass the window
			out.sof   <= need && sof;
			out.eol   <= need && eol;
		end
	end

	always_ff @(posedge clk) begin
		out.data <= pix_q;
	end

endmodule

// ==== crop_top.sv ====
`timescale 1ns/1ps
`include "crop_defines.svh"

module crop_top (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    fsync,
	input  logic                    lsync,
	input  logic                    pix_valid,
	input  logic [`CROP_PIX_W-1:0]  pix_data,
	input  logic                    cfg_wr,
	input  logic                    cfg_sel,
	input  crop_pkg::cfg_word_u     cfg_word,
	output crop_pkg::crop_pix_t     out,
	output logic [31:0]             frame_count,
	output logic [`CROP_PCNT_W-1:0] last_frame_pixels
);

	import crop_pkg::*;

	raster_pos_t            pos;
	win_cfg_t               win;
	logic [`CROP_PIX_W-1:0] pix_dly;
	logic                   need;
	logic                   sof;
	logic                   eol;

	////////////////////
	// Datapath
	////////////////////

	raster_tracker u_tracker (
		.clk       (clk),
		.resetn    (resetn),
		.fsync     (fsync),
		.lsync     (lsync),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.pos       (pos),
		.pix_dly   (pix_dly)
	);

	window_gate u_gate (
		.clk    (clk),
		.resetn (resetn),
		.fsync  (fsync),
		.lsync  (lsync),
		.pos    (pos),
		.win    (win),
		.need   (need),
		.sof    (sof),
		.eol    (eol)
	);

	crop_stream_out u_out (
		.clk     (clk),
		.resetn  (resetn),
		.pix_dly (pix_dly),
		.need    (need),
		.sof     (sof),
		.eol     (eol),
		.out     (out)
	);

	////////////////////
	// Control
	////////////////////

	crop_ctrl u_ctrl (
		.clk               (clk),
		.resetn            (resetn),
		.fsync             (fsync),
		.cfg_wr            (cfg_wr),
		.cfg_sel           (cfg_sel),
		.cfg_word          (cfg_word),
		.beat_valid        (out.valid),
		.win               (win),
		.frame_count       (frame_count),
		.last_frame_pixels (last_frame_pixels)
	);

endmodule

// ==== list.f ====
+incdir+.
crop_pkg.sv
raster_tracker.sv
window_gate.sv
crop_ctrl.sv
crop_stream_out.sv
crop_top.sv
tb_crop_top.sv

// ==== raster_tracker.sv ====
`timescale 1ns/1ps
`include "crop_defines.svh"

module raster_tracker (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   fsync,
	input  logic                   lsync,
	input  logic                   pix_valid,
	input  logic [`CROP_PIX_W-1:0] pix_data,
	output crop_pkg::raster_pos_t  pos,
	output logic [`CROP_PIX_W-1:0] pix_dly
);

	logic [`CROP_COL_W-1:0] col_cnt;
	logic [`CROP_COL_W-1:0] col_idx;
	logic [`CROP_COL_W-1:0] col_idx_next;
	logic                   col_update;
	logic [`CROP_ROW_W-1:0] row_idx;
	logic                   row_update;
	logic                   first_line;

	////////////////////
	// Column tracking
	////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			col_cnt    <= '0;
			col_update <= 1'b0;
		end else if (lsync) begin
			col_cnt    <= '0;
			col_update <= 1'b0;
		end else begin
			col_update <= pix_valid;
			if (pix_valid)
				col_cnt <= col_cnt + 1'b1;
		end
	end

	// Position and sample of the strobed pixel
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			col_idx      <= col_cnt;
			col_idx_next <= col_cnt + 1'b1;
			pix_dly      <= pix_data;
		end
	end

	////////////////////
	// Row tracking
	////////////////////

	// First lsync after fsync starts row 0
	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_idx    <= '0;
			row_update <= 1'b0;
			first_line <= 1'b0;
		end else begin
			row_update <= lsync;
			if (fsync)
				first_line <= 1'b1;
			else if (lsync) begin
				first_line <= 1'b0;
				row_idx    <= first_line ? '0 : row_idx + 1'b1;
			end
		end
	end

	assign pos.col_idx      = col_idx;
	assign pos.col_idx_next = col_idx_next;
	assign pos.col_update   = col_update;
	assign pos.row_idx      = row_idx;
	assign pos.row_update   = row_update;

endmodule

// ==== tb_crop_top.sv ====
`timescale 1ns/1ps
`include "crop_defines.svh"

module tb_crop_top;

	import crop_pkg::*;

	localparam int FRAME_W       = 16;
	localparam int FRAME_H       = 10;
	localparam int DRAIN_TIMEOUT = 500;
	localparam int SEED          = 32'hfb1236df;

	// One expected output beat with the edge where it must be seen
	typedef struct packed {
		logic [31:0] row;
		logic [31:0] col;
		logic [31:0] data;
		logic        sof;
		logic        eol;
		logic [31:0] out_cycle;
	} exp_beat_t;

	logic                    clk;
	logic                    resetn;
	logic                    fsync;
	logic                    lsync;
	logic                    pix_valid;
	logic [`CROP_PIX_W-1:0]  pix_data;
	logic                    cfg_wr;
	logic                    cfg_sel;
	cfg_word_u               cfg_word;
	crop_pix_t               out_beat;
	logic [31:0]             frame_count;
	logic [`CROP_PCNT_W-1:0] last_frame_pixels;

	// Expected beats written by the stimulus and read by the collector
	exp_beat_t exp_mem [0:4095];
	int        exp_wr = 0;
	int        exp_rd = 0;

	int cycle_cnt  = 0;
	int sof_count  = 0;
	int eol_count  = 0;

	// Pending window as written and active window as applied at fsync
	int pend_left;
	int pend_top;
	int pend_width;
	int pend_height;
	int act_left;
	int act_top;
	int act_width;
	int act_height;
	int frames_sent;
	int frame_beats;
	integer seed;

	crop_top UUT (
		.clk               (clk),
		.resetn            (resetn),
		.fsync             (fsync),
		.lsync             (lsync),
		.pix_valid         (pix_valid),
		.pix_data          (pix_data),
		.cfg_wr            (cfg_wr),
		.cfg_sel           (cfg_sel),
		.cfg_word          (cfg_word),
		.out               (out_beat),
		.frame_count       (frame_count),
		.last_frame_pixels (last_frame_pixels)
	);

	always #4 clk = ~clk;

	////////////////////
	// Checking
	////////////////////

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected)
			stop_run($sformatf("FAILED at %0t ns: %s, got %0d, expected %0d",
				$time, what, actual, expected));
	endtask

	// Collector reads registered outputs at the clock edge
	always @(posedge clk) begin
		exp_beat_t e;
		cycle_cnt = cycle_cnt + 1;
		if (resetn && out_beat.valid) begin
			if (exp_rd == exp_wr) begin
				stop_run($sformatf("Unexpected output beat at %0t ns, no pixel should pass",
					$time));
			end else begin
				e = exp_mem[exp_rd];
				exp_rd = exp_rd + 1;
				check_value(32'(out_beat.data), e.data,
					$sformatf("data at row %0d col %0d", e.row, e.col));
				check_value(32'(out_beat.sof), 32'(e.sof),
					$sformatf("sof at row %0d col %0d", e.row, e.col));
				check_value(32'(out_beat.eol), 32'(e.eol),
					$sformatf("eol at row %0d col %0d", e.row, e.col));
				check_value(32'(cycle_cnt), e.out_cycle,
					$sformatf("beat cycle at row %0d col %0d", e.row, e.col));
				sof_count  = sof_count + 32'(out_beat.sof);
				eol_count  = eol_count + 32'(out_beat.eol);
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	function automatic logic [7:0] pixel_value(input int r, input int c);
		return 8'(r * 37 + c * 11 + 90);
	endfunction

	task automatic drive_idle(input int n);
		pix_valid = 1'b0;
		lsync     = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Checks the statistics of the frame just ended
	task automatic pulse_fsync();
		fsync = 1'b1;
		act_left   = pend_left;
		act_top    = pend_top;
		act_width  = pend_width;
		act_height = pend_height;
		@(posedge clk);
		#1;
		fsync = 1'b0;
		frames_sent = frames_sent + 1;
		check_value(frame_count, 32'(frames_sent), "frame count");
		check_value(32'(last_frame_pixels), 32'(frame_beats), "pixels of last frame");
		frame_beats = 0;
	endtask

	task automatic write_cfg(input bit sel, input int a, input int b);
		cfg_wr  = 1'b1;
		cfg_sel = sel;
		if (sel) begin
			cfg_word.size.width  = 12'(a);
			cfg_word.size.height = 12'(b);
			pend_width  = a;
			pend_height = b;
		end else begin
			cfg_word.pos.left = 12'(a);
			cfg_word.pos.top  = 12'(b);
			pend_left = a;
			pend_top  = b;
		end
		@(posedge clk);
		#1;
		cfg_wr = 1'b0;
	endtask

	task automatic send_frame(input int width, input int height, input bit gaps);
		int        r;
		int        c;
		int        gap;
		exp_beat_t e;
		pulse_fsync();
		for (r = 0; r < height; r++) begin
			lsync = 1'b1;
			@(posedge clk);
			#1;
			lsync = 1'b0;
			for (c = 0; c < width; c++) begin
				if (gaps) begin
					gap = $random(seed) & 3;
					drive_idle(gap);
				end
				pix_valid = 1'b1;
				pix_data  = pixel_value(r, c);
				if (c >= act_left && c < act_left + act_width &&
						r >= act_top && r < act_top + act_height) begin
					e.row       = r;
					e.col       = c;
					e.data      = 32'(pixel_value(r, c));
					e.sof       = (r == act_top && c == act_left);
					e.eol       = (c + 1 == act_left + act_width);
					// Sampled at the next edge and seen three edges later
					e.out_cycle = cycle_cnt + 4;
					exp_mem[exp_wr] = e;
					exp_wr      = exp_wr + 1;
					frame_beats = frame_beats + 1;
				end
				@(posedge clk);
				#1;
				pix_valid = 1'b0;
			end
			drive_idle(3);
		end
		drive_idle(3);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_rd != exp_wr && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			#1;
			waited = waited + 1;
		end
		if (exp_rd != exp_wr)
			stop_run("Timeout while waiting for the cropped pixels to come out");
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic no_config_frames();
		send_frame(FRAME_W, FRAME_H, 1'b0);
		send_frame(FRAME_W, FRAME_H, 1'b0);
		wait_drain();
		pulse_fsync();
		check_value(32'(last_frame_pixels), 0, "pixels with no window written");
		check_value(frame_count, 3, "fsync pulses with no window written");
	endtask

	task automatic inner_window();
		int base_sof;
		int base_eol;
		base_sof = sof_count;
		base_eol = eol_count;
		write_cfg(1'b0, 3, 2);
		write_cfg(1'b1, 5, 4);
		send_frame(FRAME_W, FRAME_H, 1'b0);
		wait_drain();
		pulse_fsync();
		check_value(32'(last_frame_pixels), 5 * 4, "inner window pixel count");
		check_value(32'(sof_count - base_sof), 1, "sof beats in inner window");
		check_value(32'(eol_count - base_eol), 4, "eol beats in inner window");
	endtask

	// Window runs past the right and the bottom edge
	task automatic edge_window();
		int base_eol;
		base_eol = eol_count;
		write_cfg(1'b0, 12, 7);
		write_cfg(1'b1, 8, 6);
		send_frame(FRAME_W, FRAME_H, 1'b0);
		wait_drain();
		pulse_fsync();
		check_value(32'(last_frame_pixels), (FRAME_W - 12) * (FRAME_H - 7), "edge window count");
		check_value(32'(eol_count - base_eol), 0, "eol beats in edge window");
	endtask

	task automatic mid_frame_write();
		int base_eol;
		fork
			send_frame(FRAME_W, FRAME_H, 1'b0);
			begin
				repeat (40) @(posedge clk);
				#1;
				write_cfg(1'b0, 1, 1);
				write_cfg(1'b1, 6, 3);
			end
		join
		wait_drain();
		base_eol = eol_count;
		send_frame(FRAME_W, FRAME_H, 1'b0);
		check_value(32'(last_frame_pixels), (FRAME_W - 12) * (FRAME_H - 7),
			"frame with the write in flight");
		wait_drain();
		pulse_fsync();
		check_value(32'(last_frame_pixels), 6 * 3, "frame after the new window");
		check_value(32'(eol_count - base_eol), 3, "eol beats after the new window");
	endtask

	task automatic gapped_stream();
		write_cfg(1'b0, 2, 3);
		write_cfg(1'b1, 9, 5);
		send_frame(FRAME_W, FRAME_H, 1'b1);
		wait_drain();
		pulse_fsync();
		check_value(32'(last_frame_pixels), 9 * 5, "gapped stream pixel count");
	endtask

	initial begin
		clk       = 1'b0;
		resetn    = 1'b0;
		fsync     = 1'b0;
		lsync     = 1'b0;
		pix_valid = 1'b0;
		pix_data  = '0;
		cfg_wr    = 1'b0;
		cfg_sel   = 1'b0;
		cfg_word  = '0;
		seed      = SEED;
		pend_left = 0;
		pend_top  = 0;
		pend_width  = 0;
		pend_height = 0;
		frames_sent = 0;
		frame_beats = 0;
		repeat (10) @(posedge clk);
		#1;
		resetn = 1'b1;
		drive_idle(2);

		no_config_frames();
		inner_window();
		edge_window();
		mid_frame_write();
		gapped_stream();

		if (exp_rd != exp_wr) begin
			stop_run("Some expected output beats never arrived");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// ==== window_gate.sv ====
`timescale 1ns/1ps
`include "crop_defines.svh"

module window_gate (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  fsync,
	input  logic                  lsync,
	input  crop_pkg::raster_pos_t pos,
	input  crop_pkg::win_cfg_t    win,
	output logic                  need,
	output logic                  sof,
	output logic                  eol
);

	// One extra bit so the window end never wraps
	logic [`CROP_COL_W:0] col_end;
	logic [`CROP_ROW_W:0] row_end;

	logic col_need;
	logic row_need;
	logic first_line;
	logic first_pixel;
	logic eol_q;
	logic pix_here;

	assign col_end = {1'b0, win.pos.left} + {1'b0, win.size.width};
	assign row_end = {1'b0, win.pos.top} + {1'b0, win.size.height};

	////////////////////
	// Inclusion state
	////////////////////

	// End match wins, so a zero width passes nothing
	always_ff @(posedge clk) begin
		if (!resetn || lsync)
			col_need <= 1'b0;
		else if (pos.col_update) begin
			if ({1'b0, pos.col_idx} == col_end)
				col_need <= 1'b0;
			else if (pos.col_idx == win.pos.left)
				col_need <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || fsync)
			row_need <= 1'b0;
		else if (pos.row_update) begin
			if ({1'b0, pos.row_idx} == row_end)
				row_need <= 1'b0;
			else if (pos.row_idx == win.pos.top)
				row_need <= 1'b1;
		end
	end

	////////////////////
	// Frame and line markers
	////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			first_line  <= 1'b0;
			first_pixel <= 1'b0;
			eol_q       <= 1'b0;
			pix_here    <= 1'b0;
		end else begin
			// Flags belong to the pixel seen one cycle earlier
			pix_here <= pos.col_update;
			if (pos.row_update)
				first_line <= (pos.row_idx == win.pos.top);
			if (pos.col_update) begin
				first_pixel <= (pos.col_idx == win.pos.left);
				eol_q       <= ({1'b0, pos.col_idx_next} == col_end);
			end
		end
	end

	// Qualified so that gaps between pixels give no beat
	assign need = col_need && row_need && pix_here;
	assign sof  = first_line && first_pixel && pix_here;
	assign eol  = eol_q && pix_here;

endmodule
